// File: clint/clint_timer.sv
// CLINT with whole-word writes only; mtime is read-only and rtc_i must be slower than clk_i/2
`include "soc_config.svh"

module clint_timer
  import soc_bus_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  bus_req_t              req_i,
  output bus_rsp_t              rsp_o,
  output logic [`NUM_HARTS-1:0] timer_irq_o,
  output logic [`NUM_HARTS-1:0] ipi_o
);

  localparam int unsigned OFS_W = $clog2(`CLINT_LENGTH);

  logic [2:0]                   rtc_q;
  logic                         rtc_rise;
  logic                         half_q;
  logic [63:0]                  mtime_q;
  logic [`NUM_HARTS-1:0]        msip_q;
  logic [`NUM_HARTS-1:0][63:0]  mtimecmp_q;
  logic [OFS_W-1:0]             ofs;
  logic [`DATA_WIDTH-1:0]       rd_data;
  logic                         rvalid_q;
  logic [`DATA_WIDTH-1:0]       rdata_q;

  // ---------------------------------------------------------------------------
  // RTC sync, edge detect and divide by two
  // ---------------------------------------------------------------------------
  assign rtc_rise = rtc_q[1] & ~rtc_q[2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rtc_q   <= '0;
      half_q  <= 1'b0;
      mtime_q <= '0;
    end else begin
      rtc_q <= {rtc_q[1:0], rtc_i};
      if (rtc_rise) begin
        half_q <= ~half_q;
        if (half_q) begin
          mtime_q <= mtime_q + 64'd1;
        end
      end
    end
  end

  // ---------------------------------------------------------------------------
  // Register access
  // ---------------------------------------------------------------------------
  assign ofs = {req_i.addr[OFS_W-1:2], 2'b00};

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      msip_q     <= '0;
      mtimecmp_q <= '1;
    end else if (req_i.req && req_i.we) begin
      for (int h = 0; h < `NUM_HARTS; h++) begin
        if (ofs == OFS_W'(`CLINT_MSIP_OFS + 4 * h)) begin
          msip_q[h] <= req_i.wdata[0];
        end
        if (ofs == OFS_W'(`CLINT_MTIMECMP_OFS + 8 * h)) begin
          mtimecmp_q[h][31:0] <= req_i.wdata;
        end
        if (ofs == OFS_W'(`CLINT_MTIMECMP_OFS + 8 * h + 4)) begin
          mtimecmp_q[h][63:32] <= req_i.wdata;
        end
      end
    end
  end

  // Holes read as zero
  always_comb begin
    rd_data = '0;
    if (ofs == OFS_W'(`CLINT_MTIME_OFS)) begin
      rd_data = mtime_q[31:0];
    end
    if (ofs == OFS_W'(`CLINT_MTIME_OFS + 4)) begin
      rd_data = mtime_q[63:32];
    end
    for (int h = 0; h < `NUM_HARTS; h++) begin
      if (ofs == OFS_W'(`CLINT_MSIP_OFS + 4 * h)) begin
        rd_data = {{(`DATA_WIDTH-1){1'b0}}, msip_q[h]};
      end
      if (ofs == OFS_W'(`CLINT_MTIMECMP_OFS + 8 * h)) begin
        rd_data = mtimecmp_q[h][31:0];
      end
      if (ofs == OFS_W'(`CLINT_MTIMECMP_OFS + 8 * h + 4)) begin
        rd_data = mtimecmp_q[h][63:32];
      end
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rd_data;
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

  // ---------------------------------------------------------------------------
  // Interrupts
  // ---------------------------------------------------------------------------
  always_comb begin
    for (int h = 0; h < `NUM_HARTS; h++) begin
      timer_irq_o[h] = (mtime_q >= mtimecmp_q[h]);
      ipi_o[h]       = msip_q[h];
    end
  end

endmodule

// File: common/soc_addr_pkg.sv
// Address map types; rule end addresses are exclusive and rules must not overlap
`include "soc_config.svh"

package soc_addr_pkg;

  localparam int unsigned NUM_TARGETS = 3;

  typedef enum logic [1:0] {
    TGT_ROM   = 2'd0,
    TGT_SPM   = 2'd1,
    TGT_CLINT = 2'd2,
    TGT_NONE  = 2'd3
  } target_e;

  // One decoder rule
  typedef struct packed {
    target_e                 idx;
    logic [`ADDR_WIDTH-1:0]  start_addr;
    logic [`ADDR_WIDTH-1:0]  end_addr;
  } addr_rule_t;

endpackage

// File: common/soc_bus_pkg.sv
// Strobe bus types; no handshake, every request gets a response one cycle later
`include "soc_config.svh"

package soc_bus_pkg;

  typedef struct packed {
    logic                     req;
    logic                     we;
    logic [`ADDR_WIDTH-1:0]   addr;
    logic [`DATA_WIDTH/8-1:0] be;
    logic [`DATA_WIDTH-1:0]   wdata;
  } bus_req_t;

  typedef struct packed {
    logic                   rvalid;
    logic                   err;
    logic [`DATA_WIDTH-1:0] rdata;
  } bus_rsp_t;

endpackage

// File: common/soc_config.svh
// Sizes and address map for a 32-bit bus; ROM and CLINT layouts assume DATA_WIDTH of 32
`ifndef SOC_CONFIG_SVH
`define SOC_CONFIG_SVH

`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define NUM_HARTS  2

// ---------------------------------------------------------------------------
// Address map with exclusive end addresses
// ---------------------------------------------------------------------------
`define ROM_BASE     32'h0000_1000
`define ROM_LENGTH   32'h0000_0100
`define ROM_WORD_TAG 16'hb007

`define SPM_BASE   32'h1000_0000
`define SPM_LENGTH 32'h0000_0400
`define SPM_DEPTH  (`SPM_LENGTH / 4)

`define CLINT_BASE   32'h0200_0000
`define CLINT_LENGTH 32'h0001_0000

// CLINT register offsets
`define CLINT_MSIP_OFS     32'h0000_0000
`define CLINT_MTIMECMP_OFS 32'h0000_4000
`define CLINT_MTIME_OFS    32'h0000_bff8

// Hold-off after reset before debug requests reach the harts
`define DBG_DELAY_CYCLES 500

`endif

// File: hdl/addr_decoder.sv
// Single-master decoder; unmatched addresses get an error response and reach no target
`include "soc_config.svh"

module addr_decoder
  import soc_bus_pkg::*;
  import soc_addr_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       ndmreset_n,
  input  bus_req_t                   bus_req_i,
  output bus_rsp_t                   bus_rsp_o,
  output bus_req_t [NUM_TARGETS-1:0] tgt_req_o,
  input  bus_rsp_t [NUM_TARGETS-1:0] tgt_rsp_i
);

  localparam addr_rule_t ADDR_MAP [NUM_TARGETS] = '{
    '{idx: TGT_ROM,   start_addr: `ROM_BASE,   end_addr: `ROM_BASE + `ROM_LENGTH},
    '{idx: TGT_SPM,   start_addr: `SPM_BASE,   end_addr: `SPM_BASE + `SPM_LENGTH},
    '{idx: TGT_CLINT, start_addr: `CLINT_BASE, end_addr: `CLINT_BASE + `CLINT_LENGTH}
  };

  target_e sel_d;
  target_e sel_q;
  logic    valid_q;

  // ---------------------------------------------------------------------------
  // Rule match
  // ---------------------------------------------------------------------------
  always_comb begin
    sel_d = TGT_NONE;
    for (int i = 0; i < NUM_TARGETS; i++) begin
      if (bus_req_i.addr >= ADDR_MAP[i].start_addr &&
          bus_req_i.addr < ADDR_MAP[i].end_addr) begin
        sel_d = ADDR_MAP[i].idx;
      end
    end
  end

  // Same fields to all targets, strobe only to the selected one
  always_comb begin
    for (int i = 0; i < NUM_TARGETS; i++) begin
      tgt_req_o[i]     = bus_req_i;
      tgt_req_o[i].req = bus_req_i.req && (sel_d == target_e'(i));
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      valid_q <= 1'b0;
      sel_q   <= TGT_NONE;
    end else begin
      valid_q <= bus_req_i.req;
      sel_q   <= bus_req_i.req ? sel_d : TGT_NONE;
    end
  end

  // ---------------------------------------------------------------------------
  // Response mux
  // ---------------------------------------------------------------------------
  always_comb begin
    bus_rsp_o = '0;
    if (sel_q == TGT_NONE) begin
      // Decode miss answers itself
      bus_rsp_o.rvalid = valid_q;
      bus_rsp_o.err    = valid_q;
    end else begin
      bus_rsp_o = tgt_rsp_i[sel_q];
    end
  end

endmodule

// File: hdl/boot_rom.sv
// Fixed tag-pattern ROM; writes are refused with err and leave the contents as they are
`include "soc_config.svh"

module boot_rom
  import soc_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  localparam int unsigned ROM_WORDS = `ROM_LENGTH / 4;
  localparam int unsigned IDX_W     = $clog2(ROM_WORDS);

  logic [IDX_W-1:0]       word_idx;
  logic                   rvalid_q;
  logic                   err_q;
  logic [`DATA_WIDTH-1:0] rdata_q;

  // Tag in the upper half, word number in the lower half
  function automatic logic [`DATA_WIDTH-1:0] rom_word(logic [IDX_W-1:0] idx);
    return {`ROM_WORD_TAG, 16'(idx)};
  endfunction

  assign word_idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
      err_q    <= req_i.req && req_i.we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      rdata_q <= req_i.we ? '0 : rom_word(word_idx);
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: err_q, rdata: rdata_q};

endmodule

// File: hdl/debug_req_gate.sv
// Blocks debug requests for DBG_DELAY_CYCLES after reset so boot code runs first
`include "soc_config.svh"

module debug_req_gate (
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic [`NUM_HARTS-1:0] debug_req_i,
  output logic [`NUM_HARTS-1:0] debug_req_o
);

  localparam int unsigned CNT_W = $clog2(`DBG_DELAY_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;

  // Down-counter that holds at zero
  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cnt_q <= CNT_W'(`DBG_DELAY_CYCLES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (cnt_q == '0) ? debug_req_i : '0;

endmodule

// File: hdl/periph_subsystem.sv
// Single-clock peripheral block; rtc_i is sampled in the clk_i domain inside the CLINT
`include "soc_config.svh"

module periph_subsystem
  import soc_bus_pkg::*;
  import soc_addr_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  ndmreset_n,
  input  logic                  rtc_i,
  input  bus_req_t              bus_req_i,
  output bus_rsp_t              bus_rsp_o,
  input  logic [`NUM_HARTS-1:0] debug_req_i,
  output logic [`NUM_HARTS-1:0] debug_req_o,
  output logic [`NUM_HARTS-1:0] timer_irq_o,
  output logic [`NUM_HARTS-1:0] ipi_o
);

  bus_req_t [NUM_TARGETS-1:0] tgt_req;
  bus_rsp_t [NUM_TARGETS-1:0] tgt_rsp;

  addr_decoder i_addr_decoder (
    .clk_i      ( clk_i      ),
    .ndmreset_n ( ndmreset_n ),
    .bus_req_i  ( bus_req_i  ),
    .bus_rsp_o  ( bus_rsp_o  ),
    .tgt_req_o  ( tgt_req    ),
    .tgt_rsp_i  ( tgt_rsp    )
  );

  boot_rom i_boot_rom (
    .clk_i      ( clk_i            ),
    .ndmreset_n ( ndmreset_n       ),
    .req_i      ( tgt_req[TGT_ROM] ),
    .rsp_o      ( tgt_rsp[TGT_ROM] )
  );

  scratchpad i_scratchpad (
    .clk_i      ( clk_i            ),
    .ndmreset_n ( ndmreset_n       ),
    .req_i      ( tgt_req[TGT_SPM] ),
    .rsp_o      ( tgt_rsp[TGT_SPM] )
  );

  clint_timer i_clint (
    .clk_i       ( clk_i              ),
    .ndmreset_n  ( ndmreset_n         ),
    .rtc_i       ( rtc_i              ),
    .req_i       ( tgt_req[TGT_CLINT] ),
    .rsp_o       ( tgt_rsp[TGT_CLINT] ),
    .timer_irq_o ( timer_irq_o        ),
    .ipi_o       ( ipi_o              )
  );

  debug_req_gate i_debug_req_gate (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o )
  );

endmodule

// File: hdl/scratchpad.sv
// Word RAM without reset; contents are undefined until written
`include "soc_config.svh"

module scratchpad
  import soc_bus_pkg::*;
(
  input  logic     clk_i,
  input  logic     ndmreset_n,
  input  bus_req_t req_i,
  output bus_rsp_t rsp_o
);

  localparam int unsigned IDX_W = $clog2(`SPM_DEPTH);
  localparam int unsigned BE_W  = `DATA_WIDTH / 8;

  logic [`DATA_WIDTH-1:0] mem_q [`SPM_DEPTH];
  logic [IDX_W-1:0]       word_idx;
  logic                   rvalid_q;
  logic [`DATA_WIDTH-1:0] rdata_q;

  assign word_idx = req_i.addr[IDX_W+1:2];

  always_ff @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  // Byte-lane write, registered read
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < BE_W; b++) begin
          if (req_i.be[b]) begin
            mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem_q[word_idx];
      end
    end
  end

  assign rsp_o = '{rvalid: rvalid_q, err: 1'b0, rdata: rdata_q};

endmodule

// File: run.sh
#!/usr/bin/env bash
# Build and run the peripheral subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
  -f vlog.f \
  --top-module tb_periph_subsystem \
  -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "SOME TESTS FAILED" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi

echo "Simulation finished without failures"

// File: test/tb_periph_subsystem.sv
// Bus requests are driven on falling edges and responses sampled one falling edge later
`include "soc_config.svh"

module tb_periph_subsystem
  import soc_bus_pkg::*;
();

  localparam int CLK_PERIOD = 40;
  localparam int TABLE_LEN  = 16;

  logic                  clk_i;
  logic                  ndmreset_n;
  logic                  rtc_i;
  bus_req_t              bus_req_i;
  bus_rsp_t              bus_rsp_o;
  logic [`NUM_HARTS-1:0] debug_req_i;
  logic [`NUM_HARTS-1:0] debug_req_o;
  logic [`NUM_HARTS-1:0] timer_irq_o;
  logic [`NUM_HARTS-1:0] ipi_o;

  // Stimulus table
  string                  t_name      [TABLE_LEN];
  logic                   t_we        [TABLE_LEN];
  logic [`ADDR_WIDTH-1:0] t_addr      [TABLE_LEN];
  logic [3:0]             t_be        [TABLE_LEN];
  logic [`DATA_WIDTH-1:0] t_wdata     [TABLE_LEN];
  logic [`DATA_WIDTH-1:0] t_exp_rdata [TABLE_LEN];
  logic                   t_exp_err   [TABLE_LEN];
  int                     n_entries;

  integer                 seed;
  logic [`DATA_WIDTH-1:0] rnd_w [4];
  int                     cycles;
  int                     pass_cnt;
  int                     fail_cnt;

  periph_subsystem dut_i (
    .clk_i       ( clk_i       ),
    .ndmreset_n  ( ndmreset_n  ),
    .rtc_i       ( rtc_i       ),
    .bus_req_i   ( bus_req_i   ),
    .bus_rsp_o   ( bus_rsp_o   ),
    .debug_req_i ( debug_req_i ),
    .debug_req_o ( debug_req_o ),
    .timer_irq_o ( timer_irq_o ),
    .ipi_o       ( ipi_o       )
  );

  // --------------------------------------------------------------------------
  // Clock, rtc and cycle count
  // --------------------------------------------------------------------------
  always #(CLK_PERIOD / 2) clk_i = ~clk_i;

  always begin
    repeat (4) @(negedge clk_i);
    rtc_i = ~rtc_i;
  end

  // Rising edges since reset release
  always @(posedge clk_i or negedge ndmreset_n) begin
    if (!ndmreset_n) begin
      cycles <= 0;
    end else begin
      cycles <= cycles + 1;
    end
  end

  initial begin
    #((TABLE_LEN * 4 + `DBG_DELAY_CYCLES + 1000) * CLK_PERIOD);
    $display("Watchdog expired before all tests completed");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] expected_rom_word(input int k);
    return {`ROM_WORD_TAG, k[15:0]};
  endfunction

  function automatic logic [31:0] merge_lanes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  be);
    logic [31:0] res;
    for (int b = 0; b < 4; b++) begin
      res[8*b +: 8] = be[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
    end
    return res;
  endfunction

  task automatic add_entry(input string name, input logic we, input logic [31:0] addr,
                           input logic [3:0] be, input logic [31:0] wdata,
                           input logic [31:0] exp_rdata, input logic exp_err);
    t_name[n_entries]      = name;
    t_we[n_entries]        = we;
    t_addr[n_entries]      = addr;
    t_be[n_entries]        = be;
    t_wdata[n_entries]     = wdata;
    t_exp_rdata[n_entries] = exp_rdata;
    t_exp_err[n_entries]   = exp_err;
    n_entries++;
  endtask

  task automatic build_table();
    for (int i = 0; i < 4; i++) begin
      rnd_w[i] = $random(seed);
    end
    n_entries = 0;
    add_entry("rom_word0", 0, `ROM_BASE, 4'hf, 0, expected_rom_word(0), 0);
    add_entry("rom_word1", 0, `ROM_BASE + 32'd4, 4'hf, 0, expected_rom_word(1), 0);
    add_entry("rom_word5", 0, `ROM_BASE + 32'd20, 4'hf, 0, expected_rom_word(5), 0);
    add_entry("rom_word63", 0, `ROM_BASE + 32'd252, 4'hf, 0, expected_rom_word(63), 0);
    add_entry("spm_write_full", 1, `SPM_BASE + 32'h10, 4'hf, rnd_w[0], 0, 0);
    add_entry("spm_write_0101", 1, `SPM_BASE + 32'h10, 4'b0101, rnd_w[1], 0, 0);
    add_entry("spm_read_merge", 0, `SPM_BASE + 32'h10, 4'hf, 0,
              merge_lanes(rnd_w[0], rnd_w[1], 4'b0101), 0);
    add_entry("spm_write_word0", 1, `SPM_BASE, 4'hf, rnd_w[2], 0, 0);
    add_entry("unmapped_read", 0, 32'h3000_0000, 4'hf, 0, 0, 1);
    add_entry("unmapped_write", 1, 32'h3000_0000, 4'hf, rnd_w[3], 0, 1);
    // Just past the scratchpad where a leak would alias word 0
    add_entry("unmapped_past_spm", 1, `SPM_BASE + `SPM_LENGTH, 4'hf, rnd_w[3], 0, 1);
    add_entry("spm_word0_kept", 0, `SPM_BASE, 4'hf, 0, rnd_w[2], 0);
    add_entry("rom_write", 1, `ROM_BASE + 32'd8, 4'hf, 32'hdead_beef, 0, 1);
    add_entry("rom_word2_kept", 0, `ROM_BASE + 32'd8, 4'hf, 0, expected_rom_word(2), 0);
    add_entry("mtimecmp1_lo_reset", 0, `CLINT_BASE + `CLINT_MTIMECMP_OFS + 32'd8, 4'hf, 0,
              32'hffff_ffff, 0);
    add_entry("msip1_reset", 0, `CLINT_BASE + `CLINT_MSIP_OFS + 32'd4, 4'hf, 0, 0, 0);
  endtask

  // Called on a falling edge, returns on the falling edge where the response is due
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [3:0] be,
                            input logic [31:0] wdata, output logic got,
                            output logic err, output logic [31:0] rdata);
    bus_req_i.req   = 1'b1;
    bus_req_i.we    = we;
    bus_req_i.addr  = addr;
    bus_req_i.be    = be;
    bus_req_i.wdata = wdata;
    @(negedge clk_i);
    bus_req_i.req = 1'b0;
    got   = bus_rsp_o.rvalid;
    err   = bus_rsp_o.err;
    rdata = bus_rsp_o.rdata;
  endtask

  task automatic finish_test(input string name, input logic ok);
    if (ok) begin
      pass_cnt++;
      $display("Test %s passed", name);
    end else begin
      fail_cnt++;
      $display("Test %s failed", name);
    end
  endtask

  // --------------------------------------------------------------------------
  // Test sequence
  // --------------------------------------------------------------------------
  initial begin
    logic        got;
    logic        err;
    logic        ok;
    logic [31:0] rdata;
    logic [31:0] t0;
    logic [31:0] t1;

    clk_i       = 1'b0;
    rtc_i       = 1'b0;
    ndmreset_n  = 1'b0;
    bus_req_i   = '0;
    debug_req_i = '1;
    seed        = 32'hd282;
    pass_cnt    = 0;
    fail_cnt    = 0;
    build_table();

    repeat (5) @(negedge clk_i);
    ndmreset_n = 1'b1;

    ok = 1'b1;
    if (ipi_o !== '0) begin
      $display("Error: irq_after_reset ipi_o expected %b actual %b", 2'b00, ipi_o);
      ok = 1'b0;
    end
    if (timer_irq_o !== '0) begin
      $display("Error: irq_after_reset timer_irq_o expected %b actual %b", 2'b00, timer_irq_o);
      ok = 1'b0;
    end
    finish_test("irq_after_reset", ok);

    while (cycles < 100) @(negedge clk_i);
    ok = 1'b1;
    if (debug_req_o !== '0) begin
      $display("Error: dbg_held expected %b actual %b", 2'b00, debug_req_o);
      ok = 1'b0;
    end
    finish_test("dbg_held", ok);

    for (int i = 0; i < n_entries; i++) begin
      bus_access(t_we[i], t_addr[i], t_be[i], t_wdata[i], got, err, rdata);
      ok = 1'b1;
      if (got !== 1'b1) begin
        $display("%s: no response in the cycle after the request", t_name[i]);
        ok = 1'b0;
      end else begin
        if (err !== t_exp_err[i]) begin
          $display("Error: %s err expected %b actual %b", t_name[i], t_exp_err[i], err);
          ok = 1'b0;
        end
        if (rdata !== t_exp_rdata[i]) begin
          $display("Error: %s rdata expected %h actual %h", t_name[i], t_exp_rdata[i], rdata);
          ok = 1'b0;
        end
      end
      finish_test(t_name[i], ok);
    end

    // Software interrupt of hart 1
    bus_access(1, `CLINT_BASE + `CLINT_MSIP_OFS + 32'd4, 4'hf, 32'd1, got, err, rdata);
    ok = 1'b1;
    if (got !== 1'b1 || err !== 1'b0) begin
      $display("msip_set: write to msip was not answered without error");
      ok = 1'b0;
    end
    if (ipi_o !== 2'b10) begin
      $display("Error: msip_set ipi_o expected %b actual %b", 2'b10, ipi_o);
      ok = 1'b0;
    end
    finish_test("msip_set", ok);

    bus_access(1, `CLINT_BASE + `CLINT_MSIP_OFS + 32'd4, 4'hf, 32'd0, got, err, rdata);
    ok = 1'b1;
    if (ipi_o !== 2'b00) begin
      $display("Error: msip_clear ipi_o expected %b actual %b", 2'b00, ipi_o);
      ok = 1'b0;
    end
    finish_test("msip_clear", ok);

    // mtime advance over 64 cycles
    bus_access(0, `CLINT_BASE + `CLINT_MTIME_OFS, 4'hf, 0, got, err, t0);
    ok = got;
    repeat (64) @(negedge clk_i);
    bus_access(0, `CLINT_BASE + `CLINT_MTIME_OFS, 4'hf, 0, got, err, t1);
    ok = ok & got;
    if (!ok) begin
      $display("mtime_step: an mtime read got no response");
    end
    // 8 or 9 rtc rising edges lie between the two samples
    if (t1 < t0 + 32'd4) begin
      $display("Error: mtime_step expected at least %0d actual %0d", t0 + 32'd4, t1);
      ok = 1'b0;
    end
    if (t1 - t0 > 32'd9) begin
      $display("Error: mtime_step expected at most %0d actual %0d", t0 + 32'd9, t1);
      ok = 1'b0;
    end
    finish_test("mtime_step", ok);

    // Compare of hart 0 down to zero
    bus_access(1, `CLINT_BASE + `CLINT_MTIMECMP_OFS, 4'hf, 32'd0, got, err, rdata);
    bus_access(1, `CLINT_BASE + `CLINT_MTIMECMP_OFS + 32'd4, 4'hf, 32'd0, got, err, rdata);
    ok = 1'b1;
    if (timer_irq_o !== 2'b01) begin
      $display("Error: mtimecmp_irq timer_irq_o expected %b actual %b", 2'b01, timer_irq_o);
      ok = 1'b0;
    end
    finish_test("mtimecmp_irq", ok);

    while (cycles < `DBG_DELAY_CYCLES + 20) @(negedge clk_i);
    ok = 1'b1;
    if (debug_req_o !== 2'b11) begin
      $display("Error: dbg_released expected %b actual %b", 2'b11, debug_req_o);
      ok = 1'b0;
    end
    finish_test("dbg_released", ok);

    // Gate is transparent now so the output follows at once
    debug_req_i = 2'b10;
    #1;
    ok = 1'b1;
    if (debug_req_o !== 2'b10) begin
      $display("Error: dbg_follow expected %b actual %b", 2'b10, debug_req_o);
      ok = 1'b0;
    end
    finish_test("dbg_follow", ok);

    $display("Tests run: %0d, passed: %0d, failed: %0d", pass_cnt + fail_cnt, pass_cnt,
             fail_cnt);
    if (fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: vlog.f
+incdir+common
common/soc_addr_pkg.sv
common/soc_bus_pkg.sv
hdl/addr_decoder.sv
hdl/boot_rom.sv
hdl/scratchpad.sv
clint/clint_timer.sv
hdl/debug_req_gate.sv
hdl/periph_subsystem.sv
test/tb_periph_subsystem.sv
